/* hdl/lock_pkg.sv */
`default_nettype none

package lock_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	localparam int ADC_W     = 18;	// error sample from the filter
	localparam int DAC_W     = 16;	// output word toward the dac
	localparam int GAIN_W    = 8;	// front panel gain
	localparam int CHAN_ID_W = 3;	// channel tag, up to 8 channels

	//////////////////////////////////////////////////
	// vector types
	//////////////////////////////////////////////////

	// signed error sample as it arrives
	typedef logic signed [ADC_W-1:0] adc_sample_t;

	// output word, bounds and init value share this
	typedef logic signed [DAC_W-1:0] dac_word_t;

	typedef logic signed [GAIN_W-1:0] gain_t;	// output multiplication factor

	typedef logic [CHAN_ID_W-1:0] chan_id_t;	// channel number

endpackage

`default_nettype wire

/* hdl/sample_router.sv */
`default_nettype none

module sample_router #(
	parameter int N_CHAN = 4	// number of output channels
) (
	input  wire                    clk_in,		// system clock
	input  wire                    reset_in,	// sync reset, active high

	input  lock_pkg::adc_sample_t  sample_in,		// tagged error sample
	input  lock_pkg::chan_id_t     sample_chan_in,	// destination channel
	input  wire                    sample_valid_in,	// one cycle strobe

	output lock_pkg::adc_sample_t  chan_sample,	// registered sample, common to all
	output logic [N_CHAN-1:0]      chan_valid	// one hot strobe per channel
);

	//////////////////////////////////////////////////
	// tag decode
	//////////////////////////////////////////////////

	logic [N_CHAN-1:0] valid_dec;	// decoded strobe before register

	always_comb begin
		valid_dec = '0;	// out of range tags match nothing
		for (int k = 0; k < N_CHAN; k++) begin
			if (sample_valid_in && (sample_chan_in == lock_pkg::chan_id_t'(k))) begin
				valid_dec[k] = 1'b1;	// strobe only the tagged channel
			end
		end
	end

	//////////////////////////////////////////////////
	// output registers
	//////////////////////////////////////////////////

	// sample payload, loaded on every strobe
	always_ff @(posedge clk_in) begin
		if (sample_valid_in) begin
			chan_sample <= sample_in;	// hold until the next strobe
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			chan_valid <= '0;	// no strobe out of reset
		end else begin
			chan_valid <= valid_dec;	// one cycle after the input strobe
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// two channels must never start on the same sample
	chan_valid_onehot: assert property (
		@(posedge clk_in) disable iff (reset_in)
		$onehot0(chan_valid)
	) else $error("sample_router: chan_valid not one hot (%b)", chan_valid);

endmodule

`default_nettype wire

/* hdl/output_preprocessor.sv */
`default_nettype none

module output_preprocessor #(
	parameter int COMP_LATENCY = 3	// cycles spent in compute
) (
	input  wire                    clk_in,		// system clock
	input  wire                    reset_in,	// sync reset, active high

	input  lock_pkg::adc_sample_t  data_in,		// sample from router
	input  wire                    data_valid_in,	// strobe for this channel

	input  lock_pkg::dac_word_t    output_max_in,	// upper bound
	input  lock_pkg::dac_word_t    output_min_in,	// lower bound
	input  lock_pkg::dac_word_t    output_init_in,	// value when unlocked
	input  lock_pkg::gain_t        multiplier_in,	// output gain
	input  wire                    lock_en_in,	// low selects init value
	input  wire                    update_en_in,	// channel listens to update
	input  wire                    update_in,	// load pulse for parameters

	output lock_pkg::dac_word_t    data_out,	// result word
	output logic                   data_valid_out	// one cycle result strobe
);

	localparam int CNT_W = (COMP_LATENCY > 1) ? $clog2(COMP_LATENCY) : 1;	// compute counter

	typedef enum logic [1:0] {
		ST_IDLE,	// wait for a sample
		ST_COMPUTE,	// let the datapath settle
		ST_SEND,	// result valid downstream
		ST_DONE		// latch result as previous output
	} state_t;

	//////////////////////////////////////////////////
	// registers
	//////////////////////////////////////////////////

	state_t              state;			// current state
	state_t              next_state;		// next state
	logic [CNT_W-1:0]    counter;		// cycles in compute

	lock_pkg::dac_word_t sample_q;		// captured sample, top bits
	lock_pkg::dac_word_t data_out_prev;	// accumulated output

	lock_pkg::dac_word_t output_max;	// active upper bound
	lock_pkg::dac_word_t output_min;	// active lower bound
	lock_pkg::dac_word_t output_init;	// active init value
	lock_pkg::gain_t     multiplier;	// active gain

	wire load_params = update_in && update_en_in;	// front panel load this edge

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////

	logic signed [lock_pkg::DAC_W+lock_pkg::GAIN_W-1:0] prod_full;	// full product
	lock_pkg::dac_word_t prod_wrap;	// low bits, wraps
	lock_pkg::dac_word_t sum;		// product plus previous, wraps
	lock_pkg::dac_word_t clamp_hi;	// after upper bound
	lock_pkg::dac_word_t clamp_lo;	// after lower bound

	assign prod_full = sample_q * multiplier;
	assign prod_wrap = prod_full[lock_pkg::DAC_W-1:0];
	assign sum       = prod_wrap + data_out_prev;
	assign clamp_hi  = (sum < output_max) ? sum : output_max;	// max first
	assign clamp_lo  = (clamp_hi > output_min) ? clamp_hi : output_min;	// then min
	assign data_out  = lock_en_in ? clamp_lo : output_init;	// unlocked holds init

	assign data_valid_out = (state == ST_SEND);	// high only in send

	//////////////////////////////////////////////////
	// sample and accumulator
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if ((state == ST_IDLE) && data_valid_in) begin
			sample_q <= data_in[lock_pkg::ADC_W-1 -: lock_pkg::DAC_W];	// arith shift by 2
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			data_out_prev <= '0;
		end else if (load_params) begin
			data_out_prev <= output_init_in;	// restart accumulation
		end else if (state == ST_DONE) begin
			data_out_prev <= data_out;	// result becomes history
		end
	end

	// front panel parameters, loaded on the update edge
	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			output_max  <= '0;
			output_min  <= '0;
			output_init <= '0;
			multiplier  <= '0;
		end else if (load_params) begin
			output_max  <= output_max_in;
			output_min  <= output_min_in;
			output_init <= output_init_in;
			multiplier  <= multiplier_in;
		end
	end

	//////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state   <= ST_IDLE;
			counter <= '0;
		end else begin
			state   <= next_state;
			counter <= (next_state == ST_COMPUTE && state == ST_COMPUTE) ? counter + 1'b1 : '0;
		end
	end

	always_comb begin
		next_state = state;	// hold by default
		case (state)
			ST_IDLE:    if (data_valid_in) next_state = ST_COMPUTE;	// capture edge
			ST_COMPUTE: if (counter == CNT_W'(COMP_LATENCY-1)) next_state = ST_SEND;
			ST_SEND:    next_state = ST_DONE;
			ST_DONE:    next_state = ST_IDLE;
			default:    next_state = ST_IDLE;
		endcase
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// a capture gives one result strobe, COMP_LATENCY+1 cycles later
	result_timing: assert property (
		@(posedge clk_in) disable iff (reset_in)
		(state == ST_IDLE && data_valid_in) |->
			##(COMP_LATENCY+1) data_valid_out ##1 !data_valid_out
	) else $error("output_preprocessor: data_valid_out mistimed or longer than one cycle");

	// bounds loaded from the front panel must stay ordered
	bounds_ordered: assert property (
		@(posedge clk_in) disable iff (reset_in)
		load_params |=> (output_min <= output_max)
	) else $error("output_preprocessor: min %0d above max %0d", output_min, output_max);

endmodule

`default_nettype wire

/* hdl/dac_queue.sv */
`default_nettype none

module dac_queue #(
	parameter int N_CHAN = 4	// number of channels feeding the queue
) (
	input  wire                  clk_in,		// system clock
	input  wire                  reset_in,	// sync reset, active high

	input  lock_pkg::dac_word_t  result_data [N_CHAN],	// per channel result
	input  wire [N_CHAN-1:0]     result_valid,	// per channel strobe

	output lock_pkg::dac_word_t  dac_data_out,	// word toward the dac
	output lock_pkg::chan_id_t   dac_chan_out,	// its channel tag
	output logic                 dac_valid_out	// one word per cycle at most
);

	//////////////////////////////////////////////////
	// pending slots
	//////////////////////////////////////////////////

	lock_pkg::dac_word_t slot [N_CHAN];	// held result per channel
	logic [N_CHAN-1:0]   pending;	// slot waiting for its turn
	logic [N_CHAN-1:0]   request;	// pending or arriving now

	assign request = pending | result_valid;	// fresh results compete at once

	//////////////////////////////////////////////////
	// lowest index arbiter
	//////////////////////////////////////////////////

	logic [N_CHAN-1:0]   grant;		// one hot winner
	lock_pkg::dac_word_t sel_data;	// winner's word
	lock_pkg::chan_id_t  sel_chan;	// winner's tag

	// descending scan, the last hit is the lowest index
	always_comb begin
		grant    = '0;
		sel_data = '0;
		sel_chan = '0;
		for (int i = N_CHAN-1; i >= 0; i--) begin
			if (request[i]) begin
				grant    = '0;
				grant[i] = 1'b1;
				sel_data = result_valid[i] ? result_data[i] : slot[i];	// bypass when fresh
				sel_chan = lock_pkg::chan_id_t'(i);
			end
		end
	end

	//////////////////////////////////////////////////
	// slot update
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		for (int i = 0; i < N_CHAN; i++) begin
			if (result_valid[i]) begin
				slot[i] <= result_data[i];	// newest result wins
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			pending <= '0;
		end else begin
			pending <= request & ~grant;	// winner leaves, others wait
		end
	end

	//////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (|request) begin
			dac_data_out <= sel_data;
			dac_chan_out <= sel_chan;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			dac_valid_out <= 1'b0;
		end else begin
			dac_valid_out <= |request;	// any winner gives a pulse
		end
	end

	// a channel must not deliver again before its last word left
	no_slot_overwrite: assert property (
		@(posedge clk_in) disable iff (reset_in)
		(result_valid & pending) == '0
	) else $error("dac_queue: result overwrote pending slot (%b)", result_valid & pending);

endmodule

`default_nettype wire

/* hdl/lock_output_top.sv */
`default_nettype none

module lock_output_top #(
	parameter int N_CHAN       = 4,	// output channels, at most COMP_LATENCY+3
	parameter int COMP_LATENCY = 3	// preprocessor compute cycles
) (
	input  wire                    clk_in,		// system clock
	input  wire                    reset_in,	// sync reset, active high

	input  lock_pkg::adc_sample_t  sample_in,		// error sample
	input  lock_pkg::chan_id_t     sample_chan_in,	// its channel tag
	input  wire                    sample_valid_in,	// one cycle strobe

	input  lock_pkg::dac_word_t    output_max_in,	// shared upper bound
	input  lock_pkg::dac_word_t    output_min_in,	// shared lower bound
	input  lock_pkg::dac_word_t    output_init_in,	// shared init value
	input  lock_pkg::gain_t        multiplier_in,	// shared gain
	input  wire [N_CHAN-1:0]       lock_en_in,	// per channel lock level
	input  wire [N_CHAN-1:0]       update_en_in,	// per channel update select
	input  wire                    update_in,	// parameter load pulse

	output lock_pkg::dac_word_t    dac_data_out,	// queued output word
	output lock_pkg::chan_id_t     dac_chan_out,	// its channel
	output logic                   dac_valid_out	// one cycle strobe
);

	//////////////////////////////////////////////////
	// internal nets
	//////////////////////////////////////////////////

	lock_pkg::adc_sample_t chan_sample;		// common sample bus
	logic [N_CHAN-1:0]     chan_valid;		// per channel strobe
	lock_pkg::dac_word_t   result_data [N_CHAN];	// preprocessor results
	logic [N_CHAN-1:0]     result_valid;	// result strobes

	sample_router #(
		.N_CHAN (N_CHAN)
	) u_router (
		.clk_in          (clk_in),
		.reset_in        (reset_in),
		.sample_in       (sample_in),
		.sample_chan_in  (sample_chan_in),
		.sample_valid_in (sample_valid_in),
		.chan_sample     (chan_sample),
		.chan_valid      (chan_valid)
	);

	// one preprocessor per channel, panel inputs fan out
	for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
		output_preprocessor #(
			.COMP_LATENCY (COMP_LATENCY)
		) u_opp (
			.clk_in         (clk_in),
			.reset_in       (reset_in),
			.data_in        (chan_sample),
			.data_valid_in  (chan_valid[i]),
			.output_max_in  (output_max_in),
			.output_min_in  (output_min_in),
			.output_init_in (output_init_in),
			.multiplier_in  (multiplier_in),
			.lock_en_in     (lock_en_in[i]),
			.update_en_in   (update_en_in[i]),
			.update_in      (update_in),
			.data_out       (result_data[i]),
			.data_valid_out (result_valid[i])
		);
	end

	dac_queue #(
		.N_CHAN (N_CHAN)
	) u_queue (
		.clk_in        (clk_in),
		.reset_in      (reset_in),
		.result_data   (result_data),
		.result_valid  (result_valid),
		.dac_data_out  (dac_data_out),
		.dac_chan_out  (dac_chan_out),
		.dac_valid_out (dac_valid_out)
	);

endmodule

`default_nettype wire

/* bench/lock_output_tb.sv */
`default_nettype none

module lock_output_tb;

	localparam int N_CHAN       = 4;	// channels in the DUT
	localparam int COMP_LATENCY = 3;	// compute cycles per channel
	localparam int TIMEOUT      = 20;	// cycles allowed per wait

	typedef struct {
		lock_pkg::chan_id_t    chan;		// destination channel
		lock_pkg::adc_sample_t sample;		// error sample
		logic [N_CHAN-1:0]     lock_mask;	// held on lock_en_in
		bit                    update;		// pulse update before the sample
		logic [N_CHAN-1:0]     update_mask;	// update_en_in for that pulse
		lock_pkg::dac_word_t   max_v;
		lock_pkg::dac_word_t   min_v;
		lock_pkg::dac_word_t   init_v;
		lock_pkg::gain_t       gain;
		lock_pkg::dac_word_t   exp_word;	// from the reference model
		lock_pkg::chan_id_t    exp_chan;
	} step_t;

	logic                  clk_in;
	logic                  reset_in;
	lock_pkg::adc_sample_t sample_in;
	lock_pkg::chan_id_t    sample_chan_in;
	logic                  sample_valid_in;
	lock_pkg::dac_word_t   output_max_in;
	lock_pkg::dac_word_t   output_min_in;
	lock_pkg::dac_word_t   output_init_in;
	lock_pkg::gain_t       multiplier_in;
	logic [N_CHAN-1:0]     lock_en_in;
	logic [N_CHAN-1:0]     update_en_in;
	logic                  update_in;
	lock_pkg::dac_word_t   dac_data_out;
	lock_pkg::chan_id_t    dac_chan_out;
	logic                  dac_valid_out;

	step_t steps [$];		// stimulus table
	string step_names [$];	// one label per step
	int    error_count = 0;
	int    test_count  = 0;
	int    fail_count  = 0;

	// reference model, one entry per channel
	lock_pkg::dac_word_t ref_prev [N_CHAN];	// accumulated output
	lock_pkg::dac_word_t ref_max [N_CHAN];
	lock_pkg::dac_word_t ref_min [N_CHAN];
	lock_pkg::dac_word_t ref_init [N_CHAN];
	lock_pkg::gain_t     ref_gain [N_CHAN];

	lock_output_top #(.N_CHAN (N_CHAN), .COMP_LATENCY (COMP_LATENCY)) DUT (.*);

	initial begin
		clk_in = 1'b0;
		forever #4 clk_in = ~clk_in;	// period 8
	end

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	task automatic model_update(input step_t st);
		for (int c = 0; c < N_CHAN; c++) begin
			if (st.update_mask[c]) begin
				ref_max[c]  = st.max_v;
				ref_min[c]  = st.min_v;
				ref_init[c] = st.init_v;
				ref_gain[c] = st.gain;
				ref_prev[c] = st.init_v;	// accumulation restarts here
			end
		end
	endtask

	function automatic lock_pkg::dac_word_t predict_output(input int c,
			input lock_pkg::adc_sample_t s, input bit locked);
		lock_pkg::dac_word_t scaled;
		int                  product;
		lock_pkg::dac_word_t result;
		scaled  = lock_pkg::dac_word_t'(s >>> 2);	// drop two lsbs
		product = int'(scaled) * int'(ref_gain[c]);
		result  = lock_pkg::dac_word_t'(product) + ref_prev[c];	// wraps at 16 bits
		if (result > ref_max[c])
			result = ref_max[c];	// max first
		if (result < ref_min[c])
			result = ref_min[c];	// then min
		if (!locked)
			result = ref_init[c];	// unlocked sends init
		ref_prev[c] = result;
		return result;
	endfunction

	function automatic lock_pkg::adc_sample_t rand_sample(input int span);
		int v;
		v = int'($urandom_range(2 * span, 0)) - span;	// symmetric around zero
		return lock_pkg::adc_sample_t'(v);
	endfunction

	task automatic add_step(input lock_pkg::chan_id_t ch, input lock_pkg::adc_sample_t s,
			input logic [N_CHAN-1:0] lock_m, input bit upd, input logic [N_CHAN-1:0] upd_m,
			input lock_pkg::dac_word_t mx, input lock_pkg::dac_word_t mn,
			input lock_pkg::dac_word_t ini, input lock_pkg::gain_t g, input string name);
		step_t st;
		st = '{ch, s, lock_m, upd, upd_m, mx, mn, ini, g, '0, ch};
		if (upd)
			model_update(st);
		st.exp_word = predict_output(int'(ch), s, lock_m[ch]);
		steps.push_back(st);
		step_names.push_back(name);
	endtask

	//////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////

	task automatic build_table();
		ref_prev = '{default: '0};	// matches reset
		ref_max  = '{default: '0};
		ref_min  = '{default: '0};
		ref_init = '{default: '0};
		ref_gain = '{default: '0};
		add_step(3'd0, lock_pkg::adc_sample_t'($urandom), 4'b1110, 1'b1, 4'b1111,
			16'sd2000, -16'sd2000, 16'sd100, 8'sd3, "unlocked ch0 gives init");
		add_step(3'd0, lock_pkg::adc_sample_t'($urandom), 4'b1110, 1'b0, '0, '0, '0, '0, '0,
			"unlocked ch0 ignores sample");
		add_step(3'd1, rand_sample(4000), 4'b1110, 1'b0, '0, '0, '0, '0, '0, "accumulate ch1");
		add_step(3'd1, rand_sample(4000), 4'b1110, 1'b0, '0, '0, '0, '0, '0, "accumulate ch1");
		add_step(3'd1, 18'sd40000, 4'b1110, 1'b0, '0, '0, '0, '0, '0, "clamp max ch1");
		add_step(3'd1, -18'sd40000, 4'b1110, 1'b0, '0, '0, '0, '0, '0, "clamp min ch1");
		add_step(3'd2, rand_sample(4000), 4'b1110, 1'b0, '0, '0, '0, '0, '0, "accumulate ch2");
		add_step(3'd1, rand_sample(4000), 4'b1110, 1'b1, 4'b0010,
			16'sd5000, -16'sd1000, -16'sd500, -8'sd2, "update ch1 only");
		add_step(3'd2, rand_sample(4000), 4'b1110, 1'b0, '0, '0, '0, '0, '0, "ch2 keeps state");
		add_step(3'd1, rand_sample(4000), 4'b1110, 1'b0, '0, '0, '0, '0, '0, "ch1 new gain");
		add_step(3'd0, rand_sample(4000), 4'b1111, 1'b0, '0, '0, '0, '0, '0, "lock ch0");
		add_step(3'd3, rand_sample(4000), 4'b1111, 1'b0, '0, '0, '0, '0, '0, "accumulate ch3");
		add_step(3'd0, lock_pkg::adc_sample_t'($urandom), 4'b1110, 1'b1, 4'b0001,
			16'sd1500, -16'sd1500, -16'sd300, 8'sd5, "new init ch0 unlocked");
		add_step(3'd0, rand_sample(4000), 4'b1111, 1'b0, '0, '0, '0, '0, '0, "relock ch0");
	endtask

	//////////////////////////////////////////////////
	// drive, wait and compare
	//////////////////////////////////////////////////

	task automatic apply_step(input step_t st);
		@(posedge clk_in);
		lock_en_in <= st.lock_mask;
		if (st.update) begin
			output_max_in  <= st.max_v;
			output_min_in  <= st.min_v;
			output_init_in <= st.init_v;
			multiplier_in  <= st.gain;
			update_en_in   <= st.update_mask;
			update_in      <= 1'b1;	// loads on the next edge
			@(posedge clk_in);
			update_in <= 1'b0;
		end
		@(posedge clk_in);
		sample_in       <= st.sample;
		sample_chan_in  <= st.chan;
		sample_valid_in <= 1'b1;
		@(posedge clk_in);
		sample_valid_in <= 1'b0;
	endtask

	// outputs are read on the falling edge, away from the registers
	task automatic wait_output(input string label, output bit seen);
		int cycles;
		seen   = 1'b0;
		cycles = 0;
		while (!seen && cycles < TIMEOUT) begin
			@(negedge clk_in);
			seen = dac_valid_out;
			cycles++;
		end
		if (!seen) begin
			$display("timeout: no dac output within %0d cycles (%s)", TIMEOUT, label);
			error_count++;
		end
	endtask

	task automatic check_word(input lock_pkg::dac_word_t got, input lock_pkg::dac_word_t exp,
			input string label);
		if (got !== exp) begin
			$display("Fail %0t: %s word %0d, expected %0d", $time, label, got, exp);
			error_count++;
		end
	endtask

	task automatic check_chan(input lock_pkg::chan_id_t got, input lock_pkg::chan_id_t exp,
			input string label);
		if (got !== exp) begin
			$display("Fail %0t: %s channel %0d, expected %0d", $time, label, got, exp);
			error_count++;
		end
	endtask

	task automatic end_test(input string label, input int errs_before);
		test_count++;
		if (error_count != errs_before) begin
			fail_count++;
			$display("test %0d %s: failed", test_count, label);
		end else begin
			$display("test %0d %s: ok", test_count, label);
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		bit                    seen;
		int                    errs;
		int                    c;
		lock_pkg::adc_sample_t burst [N_CHAN];
		lock_pkg::dac_word_t   burst_exp [N_CHAN];
		bit                    burst_seen [N_CHAN];
		lock_pkg::chan_id_t    bad_tag;
		reset_in        = 1'b1;
		sample_in       = '0;
		sample_chan_in  = '0;
		sample_valid_in = 1'b0;
		output_max_in   = '0;
		output_min_in   = '0;
		output_init_in  = '0;
		multiplier_in   = '0;
		lock_en_in      = '0;
		update_en_in    = '0;
		update_in       = 1'b0;
		void'($urandom(99));	// one fixed seed for the run
		build_table();
		repeat (2) @(posedge clk_in);
		reset_in <= 1'b0;

		errs = error_count;	// dac stays quiet with no samples
		for (int n = 0; n < 10; n++) begin
			@(negedge clk_in);
			if (dac_valid_out) begin
				$display("unexpected dac output %0d cycles after reset", n);
				error_count++;
			end
		end
		end_test("quiet after reset", errs);

		for (int i = 0; i < steps.size(); i++) begin
			errs = error_count;
			apply_step(steps[i]);
			wait_output(step_names[i], seen);
			if (seen) begin
				check_word(dac_data_out, steps[i].exp_word, step_names[i]);
				check_chan(dac_chan_out, steps[i].exp_chan, step_names[i]);
			end
			end_test(step_names[i], errs);
			repeat (2) @(posedge clk_in);	// channel back in idle
		end

		// one sample per channel on back to back cycles, matched by tag
		errs = error_count;
		for (int k = 0; k < N_CHAN; k++) begin
			burst[k]      = rand_sample(4000);
			burst_exp[k]  = predict_output(k, burst[k], 1'b1);
			burst_seen[k] = 1'b0;
		end
		@(posedge clk_in);
		lock_en_in <= '1;
		for (int k = 0; k < N_CHAN; k++) begin
			@(posedge clk_in);
			sample_in       <= burst[k];
			sample_chan_in  <= lock_pkg::chan_id_t'(k);
			sample_valid_in <= 1'b1;
		end
		@(posedge clk_in);
		sample_valid_in <= 1'b0;
		for (int n = 0; n < N_CHAN; n++) begin
			wait_output("burst", seen);
			c = int'(dac_chan_out);
			if (seen && c >= N_CHAN) begin
				$display("burst output carries unknown channel %0d", c);
				error_count++;
			end else if (seen && burst_seen[c]) begin
				$display("channel %0d came out twice in the burst", c);
				error_count++;
			end else if (seen) begin
				burst_seen[c] = 1'b1;
				check_word(dac_data_out, burst_exp[c], "burst");
			end
		end
		end_test("burst on all channels", errs);

		errs    = error_count;	// tags past N_CHAN are dropped
		bad_tag = lock_pkg::chan_id_t'($urandom_range(7, 5));
		@(posedge clk_in);
		sample_in       <= rand_sample(4000);
		sample_chan_in  <= bad_tag;
		sample_valid_in <= 1'b1;
		@(posedge clk_in);
		sample_valid_in <= 1'b0;
		for (int n = 0; n < TIMEOUT; n++) begin
			@(negedge clk_in);
			if (dac_valid_out) begin
				$display("output appeared for out of range channel tag %0d", bad_tag);
				error_count++;
			end
		end
		end_test("out of range tag dropped", errs);

		$display("tests %0d, failed %0d, errors %0d", test_count, fail_count, error_count);
		if (error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
hdl/lock_pkg.sv
hdl/sample_router.sv
hdl/output_preprocessor.sv
hdl/dac_queue.sv
hdl/lock_output_top.sv
bench/lock_output_tb.sv

/* Makefile */
# Verilator build and run for the lock output stage

VERILATOR ?= verilator
TOP       ?= lock_output_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	$(SIM) | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "no verdict in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
